// File: cpuTop.f
source/cpuPkg.sv
source/aluUnit.sv
source/regFile.sv
source/statusFlags.sv
source/dataPath.sv
source/controlFsm.sv
source/cpuTop.sv
testbench/tbMemory.sv
testbench/cpuTopTb.sv

// File: run.sh
#!/bin/sh
# build and run the cpuTop testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpuTopTb -f cpuTop.f -o cpuTopSim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/cpuTopSim > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// File: source/aluUnit.sv
module aluUnit (
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input cpuPkg::aluFn_t fn,
	output cpuPkg::word_t result,
	output logic carry,
	output logic overflow
);
	import cpuPkg::*;

	word_t bAdd;
	word_t sum;
	logic subtract;
	logic sumCarry;

	// sub is a + ~b + 1 on the same adder
	assign subtract = (fn == aluSub);
	assign bAdd = subtract ? ~b : b;
	assign {sumCarry, sum} = {1'b0, a} + {1'b0, bAdd} + {{WORD_WIDTH{1'b0}}, subtract};

	always_comb begin
		case (fn)
			aluAnd: begin
				result = a & b;
				carry = 1'b0;
				overflow = 1'b0;
			end
			aluOr: begin
				result = a | b;
				carry = 1'b0;
				overflow = 1'b0;
			end
			default: begin
				result = sum;
				carry = sumCarry;
				// same operand signs, result sign differs
				overflow = (a[WORD_WIDTH-1] == bAdd[WORD_WIDTH-1]) &&
					(sum[WORD_WIDTH-1] != a[WORD_WIDTH-1]);
			end
		endcase
	end

endmodule

// File: source/controlFsm.sv
module controlFsm (
	input logic ld,
	input logic rst,
	input logic [6:0] irHigh,
	input logic condMet,
	input logic memDone,
	output cpuPkg::ctrlWord_t ctrl,
	output logic memRead,
	output logic memWrite,
	output logic halted
);
	import cpuPkg::*;

	cpuState_t state;
	cpuState_t nextState;
	logic [3:0] opField;
	logic [2:0] modeField;
	logic isJump;
	logic isAluOp;
	logic isAluImm;
	logic isAluReg;
	logic isLoad;
	logic isLoadAbs;
	logic isStore;
	logic isTst;
	aluFn_t opFn;

	assign opField = irHigh[6:3];
	assign modeField = irHigh[2:0];

	// instruction classes kept by this core
	assign isJump = (irHigh[6:4] == 3'b110);
	assign isAluOp = opField inside {opAdd, opSub, opAnd, opOr, opTst};
	assign isAluImm = isAluOp && (modeField == modeImm);
	assign isAluReg = isAluOp && (modeField == modeReg);
	assign isLoad = (opField == opLd) && (modeField inside {modeImm, modeAbs});
	assign isLoadAbs = (opField == opLd) && (modeField == modeAbs);
	assign isStore = (opField == opSt) && (modeField == modeAbs);
	assign isTst = (opField == opTst);

	always_comb begin
		case (opField)
			opAdd: opFn = aluAdd;
			opAnd: opFn = aluAnd;
			opOr: opFn = aluOr;
			// sub and tst share the subtractor
			default: opFn = aluSub;
		endcase
	end

	always_ff @(posedge ld or negedge rst) begin
		if (!rst) begin
			state <= stReset;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			stReset: nextState = stFetchReq;
			stFetchReq: nextState = stFetchWait;
			stFetchWait: begin
				if (memDone) begin
					nextState = stDecode;
				end
			end
			stDecode: begin
				if (isJump || isAluImm || isLoad || isStore) begin
					nextState = stOperReq;
				end else if (isAluReg) begin
					nextState = stExecute;
				end else begin
					nextState = stHalt;
				end
			end
			stOperReq: nextState = stOperWait;
			stOperWait: begin
				if (memDone) begin
					if (isJump) begin
						nextState = stJumpDecide;
					end else if (isLoadAbs || isStore) begin
						nextState = stAddrReq;
					end else begin
						nextState = stExecute;
					end
				end
			end
			stAddrReq: nextState = isStore ? stStoreWait : stLoadAddrWait;
			stLoadAddrWait: begin
				if (memDone) begin
					nextState = stExecute;
				end
			end
			stStoreWait: begin
				if (memDone) begin
					nextState = stFetchReq;
				end
			end
			stExecute, stJumpDecide: nextState = stFetchReq;
			default: nextState = stHalt;
		endcase
	end

	// one control word per state
	always_comb begin
		ctrl = '0;
		memRead = 1'b0;
		memWrite = 1'b0;
		case (state)
			stFetchReq, stOperReq: begin
				ctrl.loadMar = 1'b1;
				ctrl.marSel = marPc;
				ctrl.pcInc = 1'b1;
			end
			stFetchWait: begin
				memRead = 1'b1;
				ctrl.loadIr = 1'b1;
			end
			// Y takes R[dst] whether or not the class uses it
			stDecode: begin
				ctrl.loadY = 1'b1;
				ctrl.xSel = xReg;
				ctrl.regReadSel = readDst;
			end
			stOperWait, stLoadAddrWait: begin
				memRead = 1'b1;
				ctrl.loadMdr = 1'b1;
			end
			stAddrReq: begin
				ctrl.loadMar = 1'b1;
				ctrl.marSel = marMdr;
				if (isStore) begin
					ctrl.loadMdr = 1'b1;
					ctrl.xSel = xReg;
					ctrl.regReadSel = readDst;
				end
			end
			stStoreWait: memWrite = 1'b1;
			stExecute: begin
				if (isLoad) begin
					ctrl.regWrite = 1'b1;
					ctrl.writeSel = writeMdr;
				end else begin
					ctrl.xSel = (modeField == modeReg) ? xReg : xMdr;
					ctrl.regReadSel = readSrc;
					ctrl.aluFn = opFn;
					ctrl.loadFlags = 1'b1;
					ctrl.regWrite = !isTst;
					ctrl.writeSel = writeAlu;
				end
			end
			stJumpDecide: begin
				if (condMet) begin
					ctrl.loadPc = 1'b1;
					ctrl.xSel = xMdr;
				end
			end
			default: ;
		endcase
	end

	assign halted = (state == stHalt);

	noReadWrite: assert property (@(posedge ld) disable iff (!rst) !(memRead && memWrite))
		else $error("read and write requested in the same cycle");

endmodule

// File: source/cpuPkg.sv
package cpuPkg;

	localparam int WORD_WIDTH = 16;
	localparam int NUM_REGS = 8;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [2:0] regAddr_t;

	localparam word_t RESET_PC = '0;

	// instruction bits 15..12
	typedef enum logic [3:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opAnd = 4'd2,
		opOr = 4'd3,
		opTst = 4'd4,
		opLd = 4'd8,
		opSt = 4'd10
	} opCode_t;

	// instruction bits 11..9
	typedef enum logic [2:0] {
		modeImm = 3'd0,
		modeReg = 3'd1,
		modeAbs = 3'd3
	} addrMode_t;

	// jump condition, instruction bits 12..9
	typedef enum logic [3:0] {
		condAlways = 4'b0000,
		condZ = 4'b1000,
		condNz = 4'b1001,
		condC = 4'b1010,
		condNc = 4'b1011,
		condV = 4'b1100,
		condNv = 4'b1101,
		condS = 4'b1110,
		condNs = 4'b1111
	} condCode_t;

	typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOr} aluFn_t;

	typedef enum logic [3:0] {
		stReset, stFetchReq, stFetchWait, stDecode, stOperReq, stOperWait,
		stAddrReq, stExecute, stLoadAddrWait, stStoreWait, stJumpDecide, stHalt
	} cpuState_t;

	// sources of the MAR, the X bus, the register read port and the write data
	typedef enum logic {marPc, marMdr} marSrc_t;
	typedef enum logic [1:0] {xPc, xMdr, xReg} xSrc_t;
	typedef enum logic {readSrc, readDst} readSrc_t;
	typedef enum logic {writeAlu, writeMdr} writeSrc_t;

	typedef struct packed {
		logic z;
		logic c;
		logic v;
		logic s;
	} flags_t;

	typedef struct packed {
		logic loadPc;
		logic loadIr;
		logic loadMar;
		logic loadMdr;
		logic loadY;
		logic regWrite;
		logic loadFlags;
		marSrc_t marSel;
		xSrc_t xSel;
		readSrc_t regReadSel;
		writeSrc_t writeSel;
		aluFn_t aluFn;
		logic pcInc;
	} ctrlWord_t;

	typedef struct packed {
		logic read;
		logic write;
		word_t addr;
		word_t wdata;
	} memReq_t;

endpackage

// File: source/cpuTop.sv
module cpuTop (
	input logic ld,
	input logic rst,
	output cpuPkg::memReq_t memReq,
	input cpuPkg::word_t memRdata,
	input logic memDone,
	output logic halted
);
	import cpuPkg::*;

	ctrlWord_t ctrl;
	logic [6:0] irHigh;
	logic condMet;
	logic memRead;
	logic memWrite;
	word_t memAddr;
	word_t memWdata;

	controlFsm u_controlFsm (
		.ld(ld),
		.rst(rst),
		.irHigh(irHigh),
		.condMet(condMet),
		.memDone(memDone),
		.ctrl(ctrl),
		.memRead(memRead),
		.memWrite(memWrite),
		.halted(halted)
	);

	dataPath u_dataPath (
		.ld(ld),
		.rst(rst),
		.ctrl(ctrl),
		.memRdata(memRdata),
		.memDone(memDone),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.irHigh(irHigh),
		.condMet(condMet)
	);

	// strobes from the controller, address and data from the datapath
	assign memReq.read = memRead;
	assign memReq.write = memWrite;
	assign memReq.addr = memAddr;
	assign memReq.wdata = memWdata;

endmodule

// File: source/dataPath.sv
module dataPath (
	input logic ld,
	input logic rst,
	input cpuPkg::ctrlWord_t ctrl,
	input cpuPkg::word_t memRdata,
	input logic memDone,
	output cpuPkg::word_t memAddr,
	output cpuPkg::word_t memWdata,
	output logic [6:0] irHigh,
	output logic condMet
);
	import cpuPkg::*;

	word_t pc;
	word_t ir;
	word_t mar;
	word_t mdr;
	word_t y;
	word_t xBus;
	word_t regRead;
	word_t aluResult;
	word_t writeData;
	regAddr_t readAddr;
	logic aluCarry;
	logic aluOverflow;

	// src is ir[8:6] and dst is ir[2:0]
	assign readAddr = (ctrl.regReadSel == readDst) ? ir[2:0] : ir[8:6];

	always_comb begin
		case (ctrl.xSel)
			xMdr: xBus = mdr;
			xReg: xBus = regRead;
			default: xBus = pc;
		endcase
	end

	assign writeData = (ctrl.writeSel == writeMdr) ? mdr : aluResult;

	always_ff @(posedge ld or negedge rst) begin
		if (!rst) begin
			pc <= RESET_PC;
			ir <= '0;
			mar <= RESET_PC;
			mdr <= '0;
		end else begin
			// jump target arrives over the X bus from MDR
			if (ctrl.loadPc) begin
				pc <= xBus;
			end else if (ctrl.pcInc) begin
				pc <= pc + 16'd1;
			end
			if (ctrl.loadIr && memDone) begin
				ir <= memRdata;
			end
			if (ctrl.loadMar) begin
				mar <= (ctrl.marSel == marMdr) ? mdr : pc;
			end
			// read data on completion or store data from a register
			if (ctrl.loadMdr) begin
				if (memDone) begin
					mdr <= memRdata;
				end else if (ctrl.xSel == xReg) begin
					mdr <= xBus;
				end
			end
		end
	end

	always_ff @(posedge ld) begin
		if (ctrl.loadY) begin
			y <= xBus;
		end
	end

	regFile u_regFile (
		.ld(ld),
		.rst(rst),
		.readAddr(readAddr),
		.readData(regRead),
		.writeAddr(ir[2:0]),
		.writeData(writeData),
		.writeEn(ctrl.regWrite)
	);

	// Y holds R[dst], so a sub computes dst minus operand
	aluUnit u_aluUnit (
		.a(y),
		.b(xBus),
		.fn(ctrl.aluFn),
		.result(aluResult),
		.carry(aluCarry),
		.overflow(aluOverflow)
	);

	statusFlags u_statusFlags (
		.ld(ld),
		.rst(rst),
		.result(aluResult),
		.carry(aluCarry),
		.overflow(aluOverflow),
		.loadFlags(ctrl.loadFlags),
		.cond(condCode_t'(ir[12:9])),
		.condMet(condMet)
	);

	assign irHigh = ir[15:9];
	assign memAddr = mar;
	assign memWdata = mdr;

endmodule

// File: source/regFile.sv
module regFile (
	input logic ld,
	input logic rst,
	input cpuPkg::regAddr_t readAddr,
	output cpuPkg::word_t readData,
	input cpuPkg::regAddr_t writeAddr,
	input cpuPkg::word_t writeData,
	input logic writeEn
);
	import cpuPkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge ld or negedge rst) begin
		if (!rst) begin
			regs <= '{default: '0};
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// read port is combinational
	assign readData = regs[readAddr];

endmodule

// File: source/statusFlags.sv
module statusFlags (
	input logic ld,
	input logic rst,
	input cpuPkg::word_t result,
	input logic carry,
	input logic overflow,
	input logic loadFlags,
	input cpuPkg::condCode_t cond,
	output logic condMet
);
	import cpuPkg::*;

	flags_t flags;

	always_ff @(posedge ld or negedge rst) begin
		if (!rst) begin
			flags <= '0;
		end else if (loadFlags) begin
			flags.z <= (result == '0);
			flags.c <= carry;
			flags.v <= overflow;
			flags.s <= result[WORD_WIDTH-1];
		end
	end

	// unlisted codes are never taken
	always_comb begin
		case (cond)
			condAlways: condMet = 1'b1;
			condZ: condMet = flags.z;
			condNz: condMet = !flags.z;
			condC: condMet = flags.c;
			condNc: condMet = !flags.c;
			condV: condMet = flags.v;
			condNv: condMet = !flags.v;
			condS: condMet = flags.s;
			condNs: condMet = !flags.s;
			default: condMet = 1'b0;
		endcase
	end

	// condition comes straight from the fetched instruction word
	condKnown: assert property (@(posedge ld) disable iff (!rst) !$isunknown(cond))
		else $error("jump condition unknown in the instruction register");

endmodule

// File: testbench/cpuTopTb.sv
module cpuTopTb;
	import cpuPkg::*;

	localparam int NUM_STORES = 6;
	localparam word_t HALT_ADDR = 16'd56;

	logic ld;
	logic rst;
	memReq_t memReq;
	word_t memRdata;
	logic memDone;
	logic halted;
	int writeCount;
	int mismatchCount;
	int otherCount;
	logic [2:0] storeIndex;
	logic readSeen;
	word_t lastRead;
	logic timedOut;
	word_t expAddr [8];
	word_t expData [8];

	cpuTop u_cpuTop (
		.ld(ld),
		.rst(rst),
		.memReq(memReq),
		.memRdata(memRdata),
		.memDone(memDone),
		.halted(halted)
	);

	tbMemory u_memory (
		.ld(ld),
		.rst(rst),
		.memReq(memReq),
		.memRdata(memRdata),
		.memDone(memDone),
		.writeCount(writeCount)
	);

	initial ld = 1'b0;
	always #20 ld = ~ld;

	// words fetched only if a jump goes the wrong way
	function automatic logic onSkippedPath(input word_t a);
		return a inside {16'd28, 16'd29, 16'd40, 16'd41, 16'd48, 16'd49,
			16'd52, 16'd53, 16'h0070, 16'h0071};
	endfunction

	always @(posedge ld or negedge rst) begin
		if (!rst) begin
			storeIndex <= '0;
			readSeen <= 1'b0;
			lastRead <= '0;
		end else begin
			if (memDone && memReq.write) begin
				storeIndex <= storeIndex + 3'd1;
			end
			if (memReq.read) begin
				readSeen <= 1'b1;
				lastRead <= memReq.addr;
			end
		end
	end

	quietAfterReset: assert property (@(posedge ld) disable iff (!rst)
		!readSeen |-> !halted && !memReq.write && (!memReq.read || memReq.addr == RESET_PC))
		else begin
			mismatchCount++;
			$display("mismatch at %0t: first bus activity is not a read of %h", $time, RESET_PC);
		end

	requestStable: assert property (@(posedge ld) disable iff (!rst)
		(memReq.read || memReq.write) && !memDone |=> $stable(memReq))
		else begin
			otherCount++;
			$display("request changed before memDone at %0t", $time);
		end

	oneDirection: assert property (@(posedge ld) disable iff (!rst)
		!(memReq.read && memReq.write))
		else begin
			otherCount++;
			$display("read and write were both high at %0t", $time);
		end

	extraStore: assert property (@(posedge ld) disable iff (!rst)
		memDone && memReq.write |-> storeIndex < 3'(NUM_STORES))
		else begin
			otherCount++;
			$display("more stores than the program holds at %0t", $time);
		end

	storeValue: assert property (@(posedge ld) disable iff (!rst)
		memDone && memReq.write && storeIndex < 3'(NUM_STORES) |->
		memReq.addr == expAddr[storeIndex] && memReq.wdata == expData[storeIndex])
		else begin
			mismatchCount++;
			$display("mismatch at %0t: store of %h to %h", $time, memReq.wdata, memReq.addr);
		end

	pathTaken: assert property (@(posedge ld) disable iff (!rst)
		memReq.read |-> !onSkippedPath(memReq.addr))
		else begin
			mismatchCount++;
			$display("mismatch at %0t: read of skipped address %h", $time, memReq.addr);
		end

	haltHolds: assert property (@(posedge ld) disable iff (!rst) halted |=> halted)
		else begin
			otherCount++;
			$display("halted dropped without a reset at %0t", $time);
		end

	haltQuiet: assert property (@(posedge ld) disable iff (!rst)
		halted |-> !memReq.read && !memReq.write)
		else begin
			otherCount++;
			$display("memory request while halted at %0t", $time);
		end

	task automatic firstReadDelay(output logic expired);
		int cycles;
		cycles = 0;
		expired = 1'b0;
		while (!memReq.read && !expired) begin
			@(posedge ld);
			#1;
			cycles++;
			if (cycles > 20) begin
				expired = 1'b1;
				otherCount++;
				$display("timeout: no read request after reset");
			end
		end
		if (!expired && cycles != 2) begin
			mismatchCount++;
			$display("mismatch at %0t: first read after %0d cycles, expected 2", $time, cycles);
		end
	endtask

	task automatic runUntilHalt(output logic expired);
		int cycles;
		cycles = 0;
		expired = 1'b0;
		while (!halted && !expired) begin
			@(posedge ld);
			#1;
			cycles++;
			if (cycles > 3000) begin
				expired = 1'b1;
				otherCount++;
				$display("timeout: the CPU never halted");
			end
		end
	endtask

	initial begin
		rst = 1'b0;
		mismatchCount = 0;
		otherCount = 0;
		timedOut = 1'b0;
		// results worked out from the instruction rules
		expData[0] = 16'd5 + 16'd3;
		expData[1] = expData[0] - expData[0];
		expData[2] = (16'h00F0 | 16'h0F0F) & 16'h0A5A;
		expData[3] = 16'h1234 | expData[2];
		expData[4] = 16'd8;
		expData[5] = 16'h7FFF + 16'd1;
		for (int i = 0; i < 8; i++) begin
			expAddr[i] = 16'h0080 + 16'(i);
		end
		repeat (10) @(posedge ld);
		#1;
		rst = 1'b1;
		firstReadDelay(timedOut);
		if (!timedOut) begin
			runUntilHalt(timedOut);
		end
		if (!timedOut) begin
			if (lastRead != HALT_ADDR) begin
				mismatchCount++;
				$display("mismatch at %0t: halted after fetch of %h", $time, lastRead);
			end
			// idle time for the halt checks
			repeat (20) @(posedge ld);
			if (writeCount != NUM_STORES) begin
				otherCount++;
				$display("memory saw %0d stores instead of %0d", writeCount, NUM_STORES);
			end
		end
		$display("run finished: %0d mismatches, %0d other errors", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/tbMemory.sv
module tbMemory (
	input logic ld,
	input logic rst,
	input cpuPkg::memReq_t memReq,
	output cpuPkg::word_t memRdata,
	output logic memDone,
	output int writeCount
);
	import cpuPkg::*;

	word_t mem [256];
	integer seed;
	logic busy;
	int waitLeft;

	function automatic word_t encodeOp(input opCode_t op, input addrMode_t mode,
		input regAddr_t src, input regAddr_t dst);
		return {op, mode, src, 3'b000, dst};
	endfunction

	function automatic word_t encodeJump(input condCode_t cond);
		return {3'b110, cond, 9'd0};
	endfunction

	// instruction word followed by its operand or target word
	task automatic place(input logic [7:0] addr, input word_t instr, input word_t operand);
		mem[addr] = instr;
		mem[addr + 8'd1] = operand;
	endtask

	initial begin
		seed = 32'h153;
		memDone = 1'b0;
		memRdata = '0;
		busy = 1'b0;
		waitLeft = 0;
		writeCount = 0;
		// unused words decode as op 14, an undefined instruction
		for (int i = 0; i < 256; i++) begin
			mem[i[7:0]] = 16'hE000 | 16'(i);
		end
		place(8'd0, encodeOp(opLd, modeImm, 3'd0, 3'd1), 16'd5);
		place(8'd2, encodeOp(opAdd, modeImm, 3'd0, 3'd1), 16'd3);
		place(8'd4, encodeOp(opSt, modeAbs, 3'd0, 3'd1), 16'h0080);
		place(8'd6, encodeOp(opLd, modeImm, 3'd0, 3'd2), 16'd8);
		mem[8'd8] = encodeOp(opSub, modeReg, 3'd1, 3'd1);
		place(8'd9, encodeOp(opSt, modeAbs, 3'd0, 3'd1), 16'h0081);
		place(8'd11, encodeOp(opLd, modeImm, 3'd0, 3'd3), 16'h00F0);
		place(8'd13, encodeOp(opOr, modeImm, 3'd0, 3'd3), 16'h0F0F);
		place(8'd15, encodeOp(opAnd, modeImm, 3'd0, 3'd3), 16'h0A5A);
		place(8'd17, encodeOp(opSt, modeAbs, 3'd0, 3'd3), 16'h0082);
		place(8'd19, encodeOp(opLd, modeAbs, 3'd0, 3'd4), 16'h0090);
		mem[8'd21] = encodeOp(opOr, modeReg, 3'd3, 3'd4);
		place(8'd22, encodeOp(opSt, modeAbs, 3'd0, 3'd4), 16'h0083);
		// equal compare, jz taken and jnz falls through
		place(8'd24, encodeOp(opTst, modeImm, 3'd0, 3'd2), 16'd8);
		place(8'd26, encodeJump(condZ), 16'd30);
		place(8'd30, encodeJump(condNz), 16'h0070);
		place(8'd32, encodeOp(opSt, modeAbs, 3'd0, 3'd2), 16'h0084);
		// borrow sets s and clears c
		place(8'd34, encodeOp(opTst, modeImm, 3'd0, 3'd2), 16'd9);
		place(8'd36, encodeJump(condC), 16'h0071);
		place(8'd38, encodeJump(condS), 16'd42);
		// signed overflow into bit 15
		place(8'd42, encodeOp(opLd, modeImm, 3'd0, 3'd5), 16'h7FFF);
		place(8'd44, encodeOp(opAdd, modeImm, 3'd0, 3'd5), 16'd1);
		place(8'd46, encodeJump(condNc), 16'd50);
		place(8'd50, encodeJump(condV), 16'd54);
		place(8'd54, encodeOp(opSt, modeAbs, 3'd0, 3'd5), 16'h0085);
		mem[8'd56] = 16'hF000;
		mem[8'h90] = 16'h1234;
	end

	// one request at a time, memDone pulses after 1 to 6 cycles
	always begin
		@(posedge ld);
		#1;
		if (!rst) begin
			busy = 1'b0;
			memDone = 1'b0;
		end else if (memDone) begin
			memDone = 1'b0;
		end else if (busy) begin
			if (waitLeft == 0) begin
				busy = 1'b0;
				memDone = 1'b1;
				if (memReq.write) begin
					mem[memReq.addr[7:0]] = memReq.wdata;
					writeCount++;
				end else begin
					memRdata = mem[memReq.addr[7:0]];
				end
			end else begin
				waitLeft--;
			end
		end else if (memReq.read || memReq.write) begin
			busy = 1'b1;
			waitLeft = $unsigned($random(seed)) % 6;
		end
	end

endmodule
